// File: Bender.yml
package:
  name: sms_loader

sources:
  - files:
      - design/loader_pkg.sv
      - design/dl_decode.sv
      - design/rom_writer.sv
      - design/cheat_assembler.sv
      - design/cart_profile.sv
      - design/sms_loader.sv
  - target: test
    files:
      - testbench/tb_sms_loader.sv

// File: design/cart_profile.sv
`timescale 1ns/100ps

module cart_profile import loader_pkg::*; #(
	parameter int DL_ADDR_W   = 25,
	parameter int CART_ADDR_W = 22
) (
	input  logic                           clk_sys,
	input  logic                           RESET,
	input  logic                           cart_wr,
	input  logic                           cart_end,
	input  logic                           sysmode_wr,
	input  logic                           dip_wr,
	input  cart_kind_e                     cart_kind,
	input  logic [DL_ADDR_W-1:0]           ioctl_addr,
	input  logic [7:0]                     ioctl_dout,
	input  logic [CART_ADDR_W-1:0]         cpu_addr,
	output logic [CART_ADDR_W-1:0]         rom_raddr,
	output logic                           is_gg,
	output logic                           palette_mode,
	output logic                           is_systeme,
	output logic                           ys_fix,
	output logic [7:0]                     sysmode,
	output logic [DIP_COUNT-1:0][7:0]      dip
);

	localparam logic [CART_ADDR_W-1:0] HDR_OFS = CART_ADDR_W'(HEADER_BYTES);

	logic [CART_ADDR_W-1:0] cart_addr;
	logic [CART_ADDR_W-1:0] cart_mask;
	logic [CART_ADDR_W-1:0] hdr_mask;  // Mask for files with a copier header
	logic                   hdr_flag;
	logic [31:0]            cart_id;

	assign cart_addr = ioctl_addr[CART_ADDR_W-1:0];

	// ============================================================
	// Masks and header detection
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_mask <= '0;
			hdr_mask  <= '0;
			hdr_flag  <= 1'b0;
		end else begin
			if (cart_wr) begin
				cart_mask <= (ioctl_addr == '0) ? '0 : (cart_mask | cart_addr);
				if (ioctl_addr == DL_ADDR_W'(HEADER_BYTES)) begin
					hdr_mask <= '0;
				end else begin
					hdr_mask <= hdr_mask | (cart_addr - HDR_OFS);
				end
			end
			if (cart_end) hdr_flag <= ioctl_addr[9]; // Odd half-KB means header
		end
	end

	// Header ID bytes, big-endian in the register
	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			for (int i = 0; i < 4; i++) begin
				if (ioctl_addr == DL_ADDR_W'(CART_ID_ADDR + i)) begin
					cart_id[8*(3-i) +: 8] <= ioctl_dout;
				end
			end
		end
	end

	// ============================================================
	// Console flags, system mode and DIP bytes
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			is_gg        <= 1'b0;
			palette_mode <= 1'b0;
			is_systeme   <= 1'b0;
			ys_fix       <= 1'b0;
			sysmode      <= '0;
			dip          <= '0;
		end else begin
			if (cart_wr) begin
				is_gg      <= (cart_kind == cart_gg);
				is_systeme <= 1'b0;
				if (cart_kind == cart_sg) palette_mode <= 1'b1; // Sticky
				if (ioctl_addr == '0) ys_fix <= 1'b0;
				if ((ioctl_addr == DL_ADDR_W'(CART_ID_ADDR + 4)) && (cart_id == YS_JP_ID)) begin
					ys_fix <= 1'b1; // Graphics fix for one title
				end
			end
			if (sysmode_wr && (ioctl_addr == '0)) begin
				is_systeme <= 1'b1;
				sysmode    <= ioctl_dout;
			end
			if (dip_wr && (ioctl_addr < DL_ADDR_W'(DIP_COUNT))) begin
				dip[ioctl_addr[$clog2(DIP_COUNT)-1:0]] <= ioctl_dout;
			end
		end
	end

	// CPU ROM address through the file mask
	assign rom_raddr = hdr_flag ? ((cpu_addr + HDR_OFS) & hdr_mask) : (cpu_addr & cart_mask);

endmodule

// File: design/cheat_assembler.sv
`timescale 1ns/100ps

module cheat_assembler import loader_pkg::*; (
	input  logic        clk_sys,
	input  logic        RESET,
	input  logic        cheat_wr,
	input  logic [3:0]  byte_sel,
	input  logic [7:0]  ioctl_dout,
	output cheat_code_t cheat_code,
	output logic        cheat_valid
);

	cheat_code_t record_q;
	logic [1:0]  field;
	logic [4:0]  lane_lsb; // Bit offset inside a 32-bit field

	assign field    = byte_sel[3:2];
	assign lane_lsb = {byte_sel[1:0], 3'b000};

	// Four fields of four bytes, low byte first
	always_ff @(posedge clk_sys) begin
		if (cheat_wr) begin
			case (field)
				2'd0:    record_q.flags[lane_lsb +: 8]   <= ioctl_dout;
				2'd1:    record_q.address[lane_lsb +: 8] <= ioctl_dout;
				2'd2:    record_q.compare[lane_lsb +: 8] <= ioctl_dout;
				default: record_q.replace[lane_lsb +: 8] <= ioctl_dout;
			endcase
		end
	end

	// Last byte closes the record
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cheat_valid <= 1'b0;
		end else begin
			cheat_valid <= cheat_wr && (byte_sel == 4'(CHEAT_BYTES - 1));
		end
	end

	assign cheat_code = record_q;

endmodule

// File: design/dl_decode.sv
`timescale 1ns/100ps

module dl_decode import loader_pkg::*; (
	input  logic       clk_sys,
	input  logic       RESET,
	input  logic       ioctl_download,
	input  logic [7:0] ioctl_index,
	input  logic       ioctl_wr,
	output logic       cart_wr,
	output logic       cheat_wr,
	output logic       sysmode_wr,
	output logic       dip_wr,
	output cart_kind_e cart_kind,
	output logic       cart_start,
	output logic       cart_end
);

	stream_kind_e stream;
	logic         cart_dl;
	logic         cart_dl_q;

	// Sort the running download by its index
	always_comb begin
		if (!ioctl_download) begin
			stream = stream_other;
		end else if (ioctl_index == CHEAT_INDEX) begin
			stream = stream_cheat;
		end else if (ioctl_index == SYSMODE_INDEX) begin
			stream = stream_sysmode;
		end else if (ioctl_index == DIP_INDEX) begin
			stream = stream_dip;
		end else begin
			stream = stream_cart; // Everything else is a ROM file
		end
	end

	// Console kind from the file extension slot
	always_comb begin
		if (ioctl_index[4:0] == 5'd2) begin
			cart_kind = cart_gg;
		end else if ((ioctl_index[4:0] == 5'd1) && (ioctl_index[6:5] == 2'b10)) begin
			cart_kind = cart_sg;
		end else begin
			cart_kind = cart_sms;
		end
	end

	assign cart_wr    = ioctl_wr & (stream == stream_cart);
	assign cheat_wr   = ioctl_wr & (stream == stream_cheat);
	assign sysmode_wr = ioctl_wr & (stream == stream_sysmode);
	assign dip_wr     = ioctl_wr & (stream == stream_dip);

	assign cart_dl = (stream == stream_cart);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_dl_q <= 1'b0;
		end else begin
			cart_dl_q <= cart_dl;
		end
	end

	// Edges of the cartridge download level
	assign cart_start = cart_dl & ~cart_dl_q;
	assign cart_end   = ~cart_dl & cart_dl_q;

endmodule

// File: design/loader_pkg.sv
package loader_pkg;

	// ============================================================
	// Download stream and cartridge kinds
	// ============================================================

	typedef enum logic [2:0] {
		stream_cart,
		stream_cheat,
		stream_sysmode,
		stream_dip,
		stream_other // No download running
	} stream_kind_e;

	typedef enum logic [1:0] {
		cart_sms,
		cart_gg,
		cart_sg // SG file, palette mode
	} cart_kind_e;

	typedef enum logic {
		wr_idle,
		wr_busy
	} wr_state_e;

	// Cheat record, integers little-endian within each field
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	// ============================================================
	// Download constants
	// ============================================================

	localparam logic [7:0] CHEAT_INDEX   = 8'hff;
	localparam logic [7:0] SYSMODE_INDEX = 8'd4;
	localparam logic [7:0] DIP_INDEX     = 8'd254;

	localparam int unsigned CART_ID_ADDR = 32'h7ffc; // ID checked at +4
	localparam logic [31:0] YS_JP_ID     = 32'h1370014f;

	localparam int unsigned HEADER_BYTES = 512; // Copier header
	localparam int unsigned CHEAT_BYTES  = 16;
	localparam int unsigned DIP_COUNT    = 3;

endpackage

// File: design/rom_writer.sv
`timescale 1ns/100ps

module rom_writer import loader_pkg::*; #(
	parameter int ROM_ADDR_W = 24
) (
	input  logic                  clk_sys,
	input  logic                  RESET,
	input  logic                  cart_start,
	input  logic                  cart_wr,
	input  logic [7:0]            ioctl_dout,
	input  logic                  mem_ack,
	output logic                  mem_req,
	output logic [ROM_ADDR_W-1:0] mem_addr,
	output logic [7:0]            mem_data,
	output logic                  ioctl_wait
);

	wr_state_e             state;
	logic [ROM_ADDR_W-1:0] wr_addr; // Next ROM byte, own count
	logic                  ack_done;

	assign ack_done = (mem_ack == mem_req);

	// ============================================================
	// Toggle handshake towards the memory
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state   <= wr_idle;
			mem_req <= 1'b0;
			wr_addr <= '0;
		end else begin
			case (state)
				wr_idle: begin
					if (cart_wr) begin
						state   <= wr_busy;
						mem_req <= ~mem_req; // New request
					end
				end
				wr_busy: begin
					if (ack_done) begin
						state   <= wr_idle;
						wr_addr <= mem_addr + 1'b1;
					end
				end
				default: state <= wr_idle;
			endcase

			if (cart_start) wr_addr <= '0; // New file starts at 0
		end
	end

	// Address and byte held for the whole request
	always_ff @(posedge clk_sys) begin
		if ((state == wr_idle) && cart_wr) begin
			mem_addr <= cart_start ? '0 : wr_addr;
			mem_data <= ioctl_dout;
		end
	end

	assign ioctl_wait = (state == wr_busy); // Hold the stream

endmodule

// File: design/sms_loader.sv
`timescale 1ns/100ps

module sms_loader import loader_pkg::*; #(
	parameter int DL_ADDR_W   = 25,
	parameter int ROM_ADDR_W  = 24,
	parameter int CART_ADDR_W = 22
) (
	input  logic                      clk_sys,
	input  logic                      RESET,
	// Download stream
	input  logic                      ioctl_download,
	input  logic [7:0]                ioctl_index,
	input  logic [DL_ADDR_W-1:0]      ioctl_addr,
	input  logic [7:0]                ioctl_dout,
	input  logic                      ioctl_wr,
	output logic                      ioctl_wait,
	// External ROM memory
	output logic                      mem_req,
	output logic [ROM_ADDR_W-1:0]     mem_addr,
	output logic [7:0]                mem_data,
	input  logic                      mem_ack,
	// CPU side
	input  logic [CART_ADDR_W-1:0]    cpu_addr,
	output logic [CART_ADDR_W-1:0]    rom_raddr,
	// Cheats and profile
	output cheat_code_t               cheat_code,
	output logic                      cheat_valid,
	output logic                      is_gg,
	output logic                      palette_mode,
	output logic                      is_systeme,
	output logic                      ys_fix,
	output logic [7:0]                sysmode,
	output logic [DIP_COUNT-1:0][7:0] dip
);

	logic       cart_wr;
	logic       cheat_wr;
	logic       sysmode_wr;
	logic       dip_wr;
	logic       cart_start;
	logic       cart_end;
	cart_kind_e cart_kind;

	dl_decode u_decode (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.cart_wr        (cart_wr),
		.cheat_wr       (cheat_wr),
		.sysmode_wr     (sysmode_wr),
		.dip_wr         (dip_wr),
		.cart_kind      (cart_kind),
		.cart_start     (cart_start),
		.cart_end       (cart_end)
	);

	rom_writer #(.ROM_ADDR_W(ROM_ADDR_W)) u_writer (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.cart_start (cart_start),
		.cart_wr    (cart_wr),
		.ioctl_dout (ioctl_dout),
		.mem_ack    (mem_ack),
		.mem_req    (mem_req),
		.mem_addr   (mem_addr),
		.mem_data   (mem_data),
		.ioctl_wait (ioctl_wait)
	);

	cheat_assembler u_cheat (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.cheat_wr    (cheat_wr),
		.byte_sel    (ioctl_addr[3:0]), // Byte slot in the record
		.ioctl_dout  (ioctl_dout),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid)
	);

	cart_profile #(.DL_ADDR_W(DL_ADDR_W), .CART_ADDR_W(CART_ADDR_W)) u_profile (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.cart_wr      (cart_wr),
		.cart_end     (cart_end),
		.sysmode_wr   (sysmode_wr),
		.dip_wr       (dip_wr),
		.cart_kind    (cart_kind),
		.ioctl_addr   (ioctl_addr),
		.ioctl_dout   (ioctl_dout),
		.cpu_addr     (cpu_addr),
		.rom_raddr    (rom_raddr),
		.is_gg        (is_gg),
		.palette_mode (palette_mode),
		.is_systeme   (is_systeme),
		.ys_fix       (ys_fix),
		.sysmode      (sysmode),
		.dip          (dip)
	);

endmodule

// File: src.f
design/loader_pkg.sv
design/dl_decode.sv
design/rom_writer.sv
design/cheat_assembler.sv
design/cart_profile.sv
design/sms_loader.sv
testbench/tb_sms_loader.sv

// File: testbench/tb_sms_loader.sv
`timescale 1ns/100ps

module tb_sms_loader import loader_pkg::*; ();

	localparam int DL_ADDR_W   = 25;
	localparam int ROM_ADDR_W  = 24;
	localparam int CART_ADDR_W = 22;
	localparam int WAIT_LIMIT  = 64; // Cycles, longest ack delay is 7
	localparam int SMS_LEN     = 1000;
	localparam int GG_LEN      = 1536;
	localparam int SG_LEN      = 64;

	logic                      clk_sys;
	logic                      RESET;
	logic                      ioctl_download;
	logic [7:0]                ioctl_index;
	logic [DL_ADDR_W-1:0]      ioctl_addr;
	logic [7:0]                ioctl_dout;
	logic                      ioctl_wr;
	logic                      ioctl_wait;
	logic                      mem_req;
	logic [ROM_ADDR_W-1:0]     mem_addr;
	logic [7:0]                mem_data;
	logic                      mem_ack;
	logic [CART_ADDR_W-1:0]    cpu_addr;
	logic [CART_ADDR_W-1:0]    rom_raddr;
	cheat_code_t               cheat_code;
	logic                      cheat_valid;
	logic                      is_gg;
	logic                      palette_mode;
	logic                      is_systeme;
	logic                      ys_fix;
	logic [7:0]                sysmode;
	logic [DIP_COUNT-1:0][7:0] dip;

	logic [31:0]            lfsr = 32'd93498;
	int                     ack_wait;
	int                     cheats_seen;
	logic [ROM_ADDR_W-1:0]  log_addr[$]; // Writes seen by the memory model
	logic [7:0]             log_data[$];
	logic [7:0]             sent[$];
	cheat_code_t            exp_cheats[$];
	logic [CART_ADDR_W-1:0] probes[7] = '{22'h0, 22'h5, 22'h1ff, 22'h200, 22'h3e7,
		22'h12345, 22'h3fffff};

	sms_loader #(.DL_ADDR_W(DL_ADDR_W), .ROM_ADDR_W(ROM_ADDR_W), .CART_ADDR_W(CART_ADDR_W))
		DUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// Galois LFSR, one step per bit
	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[6:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return v;
	endfunction

	// ============================================================
	// Reference model
	// ============================================================

	function automatic logic [CART_ADDR_W-1:0] expected_raddr(
		input logic [CART_ADDR_W-1:0] cpu,
		input int                     len
	);
		logic [CART_ADDR_W-1:0] mask;
		logic [CART_ADDR_W-1:0] res;
		mask = '0;
		if (((len / HEADER_BYTES) % 2) == 1) begin // Odd half-KB count, copier header
			for (int a = HEADER_BYTES + 1; a < len; a++) mask |= CART_ADDR_W'(a - HEADER_BYTES);
			res = (cpu + CART_ADDR_W'(HEADER_BYTES)) & mask;
		end else begin
			for (int a = 1; a < len; a++) mask |= CART_ADDR_W'(a);
			res = cpu & mask;
		end
		return res;
	endfunction

	// raw holds byte i of the download at bits 8*i
	function automatic cheat_code_t expected_cheat(input logic [127:0] raw);
		logic [127:0] rec;
		rec = '0;
		for (int i = 0; i < CHEAT_BYTES; i++) begin
			rec[(3 - i / 4) * 32 + (i % 4) * 8 +: 8] = raw[i * 8 +: 8]; // Flags on top
		end
		return cheat_code_t'(rec);
	endfunction

	function automatic logic [5:0] status_now();
		return {ioctl_wait, cheat_valid, is_gg, palette_mode, is_systeme, ys_fix};
	endfunction

	// ============================================================
	// Checks
	// ============================================================

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic check_write(input string name, input logic [ROM_ADDR_W-1:0] exp_addr,
		input logic [ROM_ADDR_W-1:0] act_addr, input logic [7:0] exp_data,
		input logic [7:0] act_data);
		if ((exp_addr !== act_addr) || (exp_data !== act_data))
			fail_run($sformatf("mismatch %s: expected %h/%h, actual %h/%h", name,
				exp_addr, exp_data, act_addr, act_data));
	endtask

	task automatic check_raddr(input string name, input logic [CART_ADDR_W-1:0] exp,
		input logic [CART_ADDR_W-1:0] act);
		if (exp !== act) fail_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_cheat(input string name, input cheat_code_t exp, input cheat_code_t act);
		if (exp !== act) fail_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_flags(input string name, input logic [5:0] exp, input logic [5:0] act);
		if (exp !== act) fail_run($sformatf("mismatch %s: expected %b, actual %b", name, exp, act));
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (exp !== act) fail_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
	endtask

	// Every file lands at ROM address 0 upward
	task automatic check_write_log(input int len, input string what);
		if (log_addr.size() != len)
			fail_run($sformatf("mismatch %s write count: expected %0d, actual %0d", what,
				len, log_addr.size()));
		for (int i = 0; i < len; i++)
			check_write($sformatf("%s write %0d", what, i), ROM_ADDR_W'(i), log_addr[i], sent[i],
				log_data[i]);
	endtask

	// ============================================================
	// Memory model and cheat monitor
	// ============================================================

	always @(posedge clk_sys) begin
		if (RESET) begin
			mem_ack  <= 1'b0;
			ack_wait <= 0;
		end else if (mem_req != mem_ack) begin
			if (ack_wait == 0) begin
				ack_wait <= 1 + int'(rand_bits(3)) % 7; // 1 to 7 cycles
			end else if (ack_wait == 1) begin
				mem_ack  <= mem_req;
				ack_wait <= 0;
				log_addr.push_back(mem_addr);
				log_data.push_back(mem_data);
			end else begin
				ack_wait <= ack_wait - 1;
			end
		end
	end

	always @(negedge clk_sys) begin
		if (!RESET && cheat_valid) begin
			if (exp_cheats.size() == 0) begin
				fail_run("cheat_valid pulsed without a finished cheat download");
			end else begin
				check_cheat($sformatf("cheat record %0d", cheats_seen), exp_cheats.pop_front(),
					cheat_code);
				cheats_seen++;
			end
		end
	end

	// ============================================================
	// Download driver
	// ============================================================

	task automatic wait_ready(input string what);
		int t;
		t = 0;
		@(negedge clk_sys);
		while (ioctl_wait) begin
			if (t == WAIT_LIMIT) fail_run($sformatf("ioctl_wait never fell during %s", what));
			t++;
			@(negedge clk_sys);
		end
	endtask

	task automatic wait_cheats(input int n);
		int t;
		t = 0;
		while (cheats_seen < n) begin
			if (t == WAIT_LIMIT) fail_run("cheat_valid did not pulse for every cheat record");
			t++;
			@(posedge clk_sys);
		end
	endtask

	task automatic start_download(input logic [7:0] idx);
		@(posedge clk_sys);
		ioctl_index    <= idx;
		ioctl_download <= 1'b1;
	endtask

	task automatic send_byte(input int addr, input logic [7:0] data, input string what);
		@(posedge clk_sys);
		ioctl_addr <= DL_ADDR_W'(addr);
		ioctl_dout <= data;
		ioctl_wr   <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		wait_ready(what);
	endtask

	// Address is left at the file length when the level drops
	task automatic end_download(input int len);
		@(posedge clk_sys);
		ioctl_addr     <= DL_ADDR_W'(len);
		ioctl_download <= 1'b0;
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic cart_download(input logic [7:0] idx, input int len, input string what);
		logic [7:0] d;
		sent.delete();
		log_addr.delete();
		log_data.delete();
		start_download(idx);
		for (int a = 0; a < len; a++) begin
			d = rand_bits(8);
			sent.push_back(d);
			send_byte(a, d, what);
		end
		end_download(len);
	endtask

	task automatic id_download(input logic [31:0] id, input string what);
		start_download(8'h01);
		send_byte(0, 8'h00, what);
		for (int i = 0; i < 4; i++) send_byte(CART_ID_ADDR + i, id[8 * (3 - i) +: 8], what);
		send_byte(CART_ID_ADDR + 4, 8'h00, what); // ID compare happens here
		end_download(CART_ID_ADDR + 5);
	endtask

	task automatic probe_raddr(input int len, input string what);
		for (int i = 0; i < 7; i++) begin
			@(posedge clk_sys);
			cpu_addr <= probes[i];
			@(negedge clk_sys);
			check_raddr($sformatf("%s cpu_addr %h", what, probes[i]),
				expected_raddr(probes[i], len), rom_raddr);
		end
	endtask

	// ============================================================
	// Test sequence
	// ============================================================

	initial begin
		logic [127:0] raw;
		logic [7:0]   mode_byte;
		logic [7:0]   dip_exp[DIP_COUNT];
		RESET          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_wr       = 1'b0;
		mem_ack        = 1'b0;
		cpu_addr       = '0;
		cheats_seen    = 0;
		repeat (8) @(posedge clk_sys);
		RESET <= 1'b0;
		@(negedge clk_sys);
		check_flags("reset flags", 6'b000000, status_now());
		check_byte("reset sysmode", 8'h00, sysmode);
		for (int i = 0; i < DIP_COUNT; i++) check_byte($sformatf("reset dip %0d", i), 8'h00, dip[i]);

		cart_download(8'h01, SMS_LEN, "SMS download");
		check_write_log(SMS_LEN, "SMS");
		check_flags("SMS flags", 6'b000000, status_now());
		probe_raddr(SMS_LEN, "SMS raddr");

		cart_download(8'h02, GG_LEN, "GG download");
		check_write_log(GG_LEN, "GG");
		check_flags("GG flags", 6'b001000, status_now());
		probe_raddr(GG_LEN, "GG raddr");

		id_download(YS_JP_ID, "title ID download");
		check_flags("title fix set", 6'b000001, status_now());
		id_download(~YS_JP_ID, "plain ID download");
		check_flags("title fix cleared", 6'b000000, status_now());

		for (int c = 0; c < 2; c++) begin
			for (int i = 0; i < CHEAT_BYTES; i++) raw[i * 8 +: 8] = rand_bits(8);
			exp_cheats.push_back(expected_cheat(raw));
			start_download(CHEAT_INDEX);
			for (int i = 0; i < CHEAT_BYTES; i++) send_byte(i, raw[i * 8 +: 8], "cheat download");
			end_download(CHEAT_BYTES);
		end
		wait_cheats(2);

		mode_byte = rand_bits(8);
		start_download(SYSMODE_INDEX);
		send_byte(0, mode_byte, "system mode download");
		end_download(1);
		start_download(DIP_INDEX);
		for (int i = 0; i < DIP_COUNT; i++) begin
			dip_exp[i] = rand_bits(8);
			send_byte(i, dip_exp[i], "DIP download");
		end
		end_download(DIP_COUNT);
		check_flags("system mode flags", 6'b000010, status_now());
		check_byte("sysmode", mode_byte, sysmode);
		for (int i = 0; i < DIP_COUNT; i++) check_byte($sformatf("dip %0d", i), dip_exp[i], dip[i]);

		cart_download(8'h41, SG_LEN, "SG download"); // Index bits 6..5 = 10, slot 1
		check_write_log(SG_LEN, "SG");
		check_flags("SG flags", 6'b000100, status_now());
		check_byte("sysmode after SG", mode_byte, sysmode);
		probe_raddr(SG_LEN, "SG raddr");

		$display("Regression passed");
		$finish;
	end

endmodule
